//--- verilog.f
hdl/icmp_pkg.sv
hdl/echo_request_decoder.sv
hdl/echo_payload_buffer.sv
hdl/echo_reply_transmitter.sv
hdl/icmp_echo_responder.sv
verification/icmp_echo_props.sv
verification/icmp_echo_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= icmp_echo_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Build, run, and pass only when the pass line shows up in the output.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)

//--- verification/icmp_echo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icmp_echo_tb;
	import icmp_pkg::*;

	localparam int FIFO_AW = 6;
	localparam int DEPTH = 1 << FIFO_AW;
	localparam int NUM_FRAMES = 80;
	localparam int OFFER_TIMEOUT = 400;
	localparam int DRAIN_TIMEOUT = 1000;
	localparam int WATCHDOG_CYCLES = 100000;
	localparam int KIND_VALID = 0;
	localparam int KIND_OTHER = 1;
	localparam int KIND_BADSUM = 2;
	localparam int KIND_RXERR = 3;
	localparam int KIND_LONG = 4;

	logic clk;
	logic reset;
	logic rx_newhead;
	icmp_head_t rx_head;
	logic rx_dven;
	logic [7:0] rx_data;
	logic rx_error;
	logic tx_ack;
	logic tx_req;
	icmp_head_t tx_head;
	logic tx_dven;
	logic [7:0] tx_data;
	logic [15:0] reply_count;
	logic [15:0] drop_count;

	integer seed = 32'hec3;
	int value_errors = 0;
	int other_errors = 0;
	int model_drops = 0;
	int answered_sent = 0;
	int offers = 0;
	int replies_done = 0;
	int cur_len = 0;
	int got_bytes = 0;
	logic req_seen = 1'b0;
	logic [7:0] frame_bytes [0:127];
	icmp_head_t exp_heads [$];
	int exp_lens [$];
	logic [7:0] exp_bytes [$];

	icmp_echo_responder #(.FIFO_AW(FIFO_AW)) dut0 (
		.clk(clk), .reset(reset), .rx_newhead(rx_newhead), .rx_head(rx_head),
		.rx_dven(rx_dven), .rx_data(rx_data), .rx_error(rx_error), .tx_ack(tx_ack),
		.tx_req(tx_req), .tx_head(tx_head), .tx_dven(tx_dven), .tx_data(tx_data),
		.reply_count(reply_count), .drop_count(drop_count)
	);

	always #2 clk = ~clk;

	task automatic check_head(input icmp_head_t got, input icmp_head_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t tx_head: got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// Fold carries back in until the sum fits 16 bits.
	function automatic logic [15:0] fold_sum(input logic [31:0] acc);
		logic [31:0] s;
		s = acc;
		while (s[31:16] != 16'd0)
			s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
		return s[15:0];
	endfunction

	function automatic logic [15:0] frame_sum(input icmp_head_t head, input int len);
		logic [31:0] acc;
		int j;
		acc = {16'd0, head[63:48]} + {16'd0, head[47:32]} +
			{16'd0, head[31:16]} + {16'd0, head[15:0]};
		for (j = 0; j < len; j += 2) begin
			if (j + 1 < len)
				acc += {16'd0, frame_bytes[j], frame_bytes[j + 1]};
			else
				acc += {16'd0, frame_bytes[j], 8'h00}; // Odd tail padded.
		end
		return fold_sum(acc);
	endfunction

	task automatic wait_for_offer(input int target);
		int cycles;
		cycles = 0;
		while (offers < target && cycles < OFFER_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (offers < target) begin
			other_errors++;
			$display("Timeout: reply %0d was not offered on the link in %0d cycles",
				target, OFFER_TIMEOUT);
		end
	endtask

	task automatic wait_for_drain;
		int cycles;
		cycles = 0;
		while ((replies_done < answered_sent || tx_req || tx_ack) &&
				cycles < DRAIN_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (replies_done < answered_sent || tx_req || tx_ack) begin
			other_errors++;
			$display("Timeout: link never went idle, %0d of %0d replies finished",
				replies_done, answered_sent);
		end
	endtask

	// Builds one frame, updates the model, drives it and waits for the verdict.
	task automatic send_frame(input int index);
		icmp_head_t head;
		icmp_head_t reply;
		int kind;
		int len;
		int err_pos;
		int r;
		int j;
		logic accepted;
		logic answered;
		@(posedge clk); // Random draws stay clear of the arbiter's edge.
		r = $random(seed);
		if (index < 8)
			kind = (index % 2 == 0) ? KIND_VALID : (index + 1) / 2; // Faults between good frames.
		else if (r[2:0] < 3'd4)
			kind = KIND_VALID;
		else
			kind = r[2:0] - 3;
		r = $random(seed);
		if (kind == KIND_LONG)
			len = DEPTH + 1 + (r & 15);
		else
			len = 1 + ((r & 32'h7fff) % (DEPTH / 2));
		for (j = 0; j < len; j++)
			frame_bytes[j] = $random(seed);
		head.msg_type = ECHO_REQUEST;
		head.code = 8'd0;
		head.checksum = 16'd0;
		head.rest_of_header = $random(seed);
		r = $random(seed);
		if (kind == KIND_OTHER) begin
			if (r[8])
				head.code = r[7:0] | 8'd1;
			else
				head.msg_type = icmp_type_e'((r[7:0] == 8'd8) ? 8'd13 : r[7:0]);
		end
		head.checksum = ~frame_sum(head, len);
		if (kind == KIND_BADSUM)
			head.checksum = head.checksum ^ (16'd1 << r[12:9]);
		err_pos = (kind == KIND_RXERR) ? (r[31:16] % len) : -1;

		accepted = (head.msg_type == ECHO_REQUEST) && (head.code == 8'd0);
		answered = accepted && (frame_sum(head, len) == 16'hFFFF) && (err_pos < 0) &&
			(len <= DEPTH);
		if (accepted && !answered)
			model_drops++;
		if (answered) begin
			reply.msg_type = ECHO_REPLY;
			reply.code = 8'd0;
			reply.checksum = fold_sum({16'd0, head.checksum} + 32'h0800); // Type 8 to 0.
			reply.rest_of_header = head.rest_of_header;
			exp_heads.push_back(reply);
			exp_lens.push_back(len);
			for (j = 0; j < len; j++)
				exp_bytes.push_back(frame_bytes[j]);
			answered_sent++;
		end

		@(negedge clk);
		rx_newhead = 1'b1;
		rx_head = head;
		for (j = 0; j < len; j++) begin
			@(negedge clk);
			rx_newhead = 1'b0;
			rx_dven = 1'b1;
			rx_data = frame_bytes[j];
			rx_error = (j == err_pos);
		end
		@(negedge clk);
		rx_dven = 1'b0;
		rx_data = 8'd0;
		rx_error = 1'b0;
		repeat (5) @(negedge clk); // Verdict is 2 cycles after the payload ends.
		check_count("drop_count", drop_count, model_drops);
		if (answered) begin
			wait_for_offer(answered_sent);
			repeat (4) @(negedge clk); // Next frame overlaps the streaming reply.
		end
	endtask

	// Link arbiter with random grant and release delays.
	initial begin : link_arbiter
		int delay;
		tx_ack = 1'b0;
		forever begin
			@(negedge clk);
			if (tx_req && !tx_ack) begin
				delay = $random(seed) & 15;
				repeat (delay) @(negedge clk);
				tx_ack = 1'b1;
			end else if (!tx_req && tx_ack) begin
				delay = $random(seed) & 3;
				repeat (delay) @(negedge clk);
				tx_ack = 1'b0;
			end
		end
	end

	// Reply monitor compares each reply with the front of the model queue.
	always @(posedge clk) begin
		if (!reset) begin
			if (tx_req && !req_seen) begin
				offers++;
				got_bytes = 0;
				if (exp_heads.size() == 0) begin
					other_errors++;
					cur_len = 0;
					$display("%0t: a reply was offered with no request pending", $time);
				end else begin
					check_head(tx_head, exp_heads.pop_front());
					cur_len = exp_lens.pop_front();
				end
			end
			if (tx_dven) begin
				if (!tx_req || got_bytes >= cur_len) begin
					other_errors++;
					$display("%0t: payload byte sent outside an expected reply", $time);
				end else begin
					check_byte("tx_data", tx_data, exp_bytes.pop_front());
					got_bytes++;
				end
			end
			if (!tx_req && req_seen) begin
				check_count("reply length", got_bytes, cur_len);
				while (got_bytes < cur_len) begin
					void'(exp_bytes.pop_front()); // Resync after a short reply.
					got_bytes++;
				end
				replies_done++;
			end
			req_seen = tx_req;
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Simulation ran past %0d cycles without finishing", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin : stimulus
		int i;
		clk = 1'b0;
		reset = 1'b1;
		rx_newhead = 1'b0;
		rx_head = '0;
		rx_dven = 1'b0;
		rx_data = 8'd0;
		rx_error = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		repeat (2) @(negedge clk);
		check_count("reply_count", reply_count, 16'd0);
		check_count("drop_count", drop_count, 16'd0);
		for (i = 0; i < NUM_FRAMES && other_errors == 0; i++)
			send_frame(i);
		wait_for_drain();
		repeat (2) @(negedge clk);
		check_count("reply_count", reply_count, answered_sent);
		check_count("drop_count", drop_count, model_drops);
		$display("Done: %0d replies, %0d drops, %0d value errors, %0d other errors",
			answered_sent, model_drops, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/icmp_echo_props.sv
`timescale 1ns/1ps
`default_nettype none

module icmp_echo_props (
	input wire                       clk,
	input wire                       reset,
	input wire                       tx_req,
	input wire                       tx_ack,
	input wire                       tx_dven,
	input wire icmp_pkg::icmp_head_t tx_head
);

	req_low_after_reset: assert property (@(posedge clk) reset |=> !tx_req)
		else $error("tx_req high right after reset");

	// Request is held until the arbiter has granted.
	req_held_until_ack: assert property (@(posedge clk) disable iff (reset)
		(tx_req && !tx_ack) |=> tx_req)
		else $error("tx_req dropped before tx_ack was seen");

	dven_inside_grant: assert property (@(posedge clk) disable iff (reset)
		tx_dven |-> (tx_req && tx_ack))
		else $error("tx_dven high outside a granted request");

	// New request only after the previous grant is gone.
	no_rise_during_ack: assert property (@(posedge clk) disable iff (reset)
		$rose(tx_req) |-> !$past(tx_ack))
		else $error("tx_req rose while tx_ack was still high");

	head_stable: assert property (@(posedge clk) disable iff (reset)
		tx_req |=> (!tx_req || $stable(tx_head)))
		else $error("tx_head changed while tx_req was high");

endmodule

bind icmp_echo_responder icmp_echo_props props0 (
	.clk(clk), .reset(reset), .tx_req(tx_req), .tx_ack(tx_ack),
	.tx_dven(tx_dven), .tx_head(tx_head)
);

`default_nettype wire

//--- hdl/icmp_echo_responder.sv
`timescale 1ns/1ps
`default_nettype none

module icmp_echo_responder #(
	parameter int FIFO_AW = 6
) (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       rx_newhead,
	input  wire icmp_pkg::icmp_head_t rx_head,
	input  wire                       rx_dven,
	input  wire [7:0]                 rx_data,
	input  wire                       rx_error,
	input  wire                       tx_ack,
	output logic                      tx_req,
	output icmp_pkg::icmp_head_t      tx_head,
	output logic                      tx_dven,
	output logic [7:0]                tx_data,
	output logic [15:0]               reply_count,
	output logic [15:0]               drop_count
);
	import icmp_pkg::*;

	reply_desc_t desc;
	logic desc_req;
	logic desc_ack;
	logic wr_en;
	logic [7:0] wr_data;
	logic commit;
	logic rollback;
	logic full;
	logic rd_en;
	logic [7:0] rd_data;

	echo_request_decoder #(.FIFO_AW(FIFO_AW)) decoder0 (
		.clk(clk), .reset(reset), .rx_newhead(rx_newhead), .rx_head(rx_head),
		.rx_dven(rx_dven), .rx_data(rx_data), .rx_error(rx_error), .full(full),
		.desc_ack(desc_ack), .wr_en(wr_en), .wr_data(wr_data), .commit(commit),
		.rollback(rollback), .desc_req(desc_req), .desc(desc), .drop_count(drop_count)
	);

	echo_payload_buffer #(.FIFO_AW(FIFO_AW)) buffer0 (
		.clk(clk), .reset(reset), .wr_en(wr_en), .wr_data(wr_data), .commit(commit),
		.rollback(rollback), .rd_en(rd_en), .rd_data(rd_data), .full(full)
	);

	echo_reply_transmitter transmitter0 (
		.clk(clk), .reset(reset), .desc_req(desc_req), .desc(desc), .rd_data(rd_data),
		.tx_ack(tx_ack), .desc_ack(desc_ack), .rd_en(rd_en), .tx_req(tx_req),
		.tx_head(tx_head), .tx_dven(tx_dven), .tx_data(tx_data), .reply_count(reply_count)
	);

endmodule

`default_nettype wire

//--- hdl/echo_reply_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

module echo_reply_transmitter (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        desc_req,
	input  wire icmp_pkg::reply_desc_t desc,
	input  wire [7:0]                  rd_data,
	input  wire                        tx_ack,
	output logic                       desc_ack,
	output logic                       rd_en,
	output logic                       tx_req,
	output icmp_pkg::icmp_head_t       tx_head,
	output logic                       tx_dven,
	output logic [7:0]                 tx_data,
	output logic [15:0]                reply_count
);
	import icmp_pkg::*;

	tx_state_e state;
	logic [15:0] remaining;
	logic take;

	assign take = (state == TX_IDLE) && desc_req && !desc_ack;
	assign rd_en = (state == TX_SEND) && (remaining != 16'd0);
	assign tx_data = rd_data; // Buffer output is already registered.

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= TX_IDLE;
			desc_ack <= 1'b0;
			tx_req <= 1'b0;
			tx_dven <= 1'b0;
			remaining <= 16'd0;
			reply_count <= 16'd0;
		end else begin
			tx_dven <= rd_en; // Read data lags rd_en by one cycle.
			if (desc_ack && !desc_req)
				desc_ack <= 1'b0; // Last phase of the descriptor handoff.
			case (state)
				TX_IDLE: begin
					if (take) begin
						desc_ack <= 1'b1;
						remaining <= desc.length;
						state <= TX_REQ;
					end
				end
				TX_REQ: begin
					if (tx_req && tx_ack)
						state <= TX_SEND; // Link granted.
					else if (!tx_ack)
						tx_req <= 1'b1;
				end
				TX_SEND: begin
					if (rd_en) begin
						remaining <= remaining - 16'd1;
					end else begin
						tx_req <= 1'b0; // Last byte is on the link now.
						reply_count <= reply_count + 16'd1;
						state <= TX_RELEASE;
					end
				end
				TX_RELEASE: begin
					if (!tx_ack)
						state <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Header holds from descriptor latch to the end of the reply.
	always_ff @(posedge clk) begin
		if (take)
			tx_head <= desc.head;
	end

endmodule

`default_nettype wire

//--- hdl/echo_payload_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module echo_payload_buffer #(
	parameter int FIFO_AW = 6
) (
	input  wire        clk,
	input  wire        reset,
	input  wire        wr_en,
	input  wire [7:0]  wr_data,
	input  wire        commit,
	input  wire        rollback,
	input  wire        rd_en,
	output logic [7:0] rd_data,
	output logic       full
);
	localparam int DEPTH = 1 << FIFO_AW;

	logic [7:0] mem [DEPTH];
	logic [FIFO_AW:0] wr_ptr; // Speculative write position.
	logic [FIFO_AW:0] cm_ptr; // End of the last committed frame.
	logic [FIFO_AW:0] rd_ptr;
	logic wr_ok;
	logic rd_ok;

	assign full = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
		(wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
	assign wr_ok = wr_en && !full;
	assign rd_ok = rd_en && (rd_ptr != cm_ptr); // Only committed bytes are visible.

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			cm_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (rollback)
				wr_ptr <= cm_ptr; // Discard the partial frame.
			else if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (commit)
				cm_ptr <= wr_ptr;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok)
			mem[wr_ptr[FIFO_AW-1:0]] <= wr_data;
		if (rd_ok)
			rd_data <= mem[rd_ptr[FIFO_AW-1:0]]; // Valid one cycle after rd_en.
	end

endmodule

`default_nettype wire

//--- hdl/echo_request_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module echo_request_decoder #(
	parameter int FIFO_AW = 6
) (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      rx_newhead,
	input  wire icmp_pkg::icmp_head_t rx_head,
	input  wire                      rx_dven,
	input  wire [7:0]                rx_data,
	input  wire                      rx_error,
	input  wire                      full,
	input  wire                      desc_ack,
	output logic                     wr_en,
	output logic [7:0]               wr_data,
	output logic                     commit,
	output logic                     rollback,
	output logic                     desc_req,
	output icmp_pkg::reply_desc_t    desc,
	output logic [15:0]              drop_count
);
	import icmp_pkg::*;

	localparam int DEPTH = 1 << FIFO_AW;

	dec_state_e state;
	icmp_head_t reply_head;
	logic [15:0] sum;
	logic [15:0] final_sum;
	logic [15:0] head_sum;
	logic [15:0] len;
	logic [7:0] hi_byte;
	logic odd;
	logic err;
	logic lost;
	logic frame_ok;
	logic pending;
	logic accept;
	logic ok;

	// One's-complement add with end-around carry.
	function automatic logic [15:0] oc_add(input logic [15:0] a, input logic [15:0] b);
		logic [16:0] s;
		s = a + b;
		return s[15:0] + {15'd0, s[16]};
	endfunction

	assign accept = rx_newhead && (state == DEC_IDLE) &&
		(rx_head.msg_type == ECHO_REQUEST) && (rx_head.code == 8'd0);
	assign head_sum = oc_add(oc_add({rx_head.msg_type, rx_head.code}, rx_head.checksum),
		oc_add(rx_head.rest_of_header[31:16], rx_head.rest_of_header[15:0]));
	assign final_sum = odd ? oc_add(sum, {hi_byte, 8'h00}) : sum; // Pad odd last byte.
	assign pending = desc_req | desc_ack; // Previous descriptor not yet taken.
	assign ok = (final_sum == 16'hFFFF) && !err && !lost && !pending &&
		(len <= DEPTH[15:0]);

	assign wr_en = (state == DEC_PAYLOAD) && rx_dven && !full && !lost;
	assign wr_data = rx_data;
	assign commit = (state == DEC_HANDOFF) && frame_ok;
	assign rollback = (state == DEC_HANDOFF) && !frame_ok;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= DEC_IDLE;
			odd <= 1'b0;
			err <= 1'b0;
			lost <= 1'b0;
			frame_ok <= 1'b0;
			desc_req <= 1'b0;
			drop_count <= 16'd0;
		end else begin
			if (desc_req && desc_ack)
				desc_req <= 1'b0; // Second phase of the handoff.
			case (state)
				DEC_IDLE: begin
					if (accept) begin
						state <= DEC_PAYLOAD;
						odd <= 1'b0;
						err <= 1'b0;
						lost <= 1'b0;
					end
				end
				DEC_PAYLOAD: begin
					if (rx_dven) begin
						odd <= ~odd;
						if (rx_error)
							err <= 1'b1;
						if (full)
							lost <= 1'b1; // Byte dropped so the frame is bad.
					end else begin
						state <= DEC_CHECK;
					end
				end
				DEC_CHECK: begin
					frame_ok <= ok;
					if (ok)
						desc_req <= 1'b1; // Rises together with commit.
					else
						drop_count <= drop_count + 16'd1;
					state <= DEC_HANDOFF;
				end
				DEC_HANDOFF: state <= DEC_IDLE;
				default: state <= DEC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			sum <= head_sum;
			len <= 16'd0;
			reply_head <= '{msg_type: ECHO_REPLY, code: 8'd0,
				checksum: oc_add(rx_head.checksum, 16'h0800),
				rest_of_header: rx_head.rest_of_header};
		end else if ((state == DEC_PAYLOAD) && rx_dven) begin
			len <= len + 16'd1;
			if (!odd)
				hi_byte <= rx_data; // High byte of the next word.
			else
				sum <= oc_add(sum, {hi_byte, rx_data});
		end
		if ((state == DEC_CHECK) && ok)
			desc <= '{head: reply_head, length: len};
	end

endmodule

`default_nettype wire

//--- hdl/icmp_pkg.sv
`default_nettype none

package icmp_pkg;

	// ICMP message types. Other values may arrive on the receive side.
	typedef enum logic [7:0] {
		ECHO_REPLY   = 8'd0,
		ECHO_REQUEST = 8'd8
	} icmp_type_e;

	// The 8-byte ICMP header with the first byte on the wire in the top bits.
	typedef struct packed {
		icmp_type_e  msg_type;
		logic [7:0]  code;
		logic [15:0] checksum;
		logic [31:0] rest_of_header; // Identifier and sequence.
	} icmp_head_t;

	// Reply handed from the decoder to the transmitter.
	typedef struct packed {
		icmp_head_t  head;   // Finished reply header.
		logic [15:0] length; // Payload bytes waiting in the buffer.
	} reply_desc_t;

	// Receive path FSM.
	typedef enum logic [1:0] {
		DEC_IDLE,
		DEC_PAYLOAD,
		DEC_CHECK,
		DEC_HANDOFF
	} dec_state_e;

	// Transmit path FSM.
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_REQ,
		TX_SEND,
		TX_RELEASE
	} tx_state_e;

endpackage

`default_nettype wire
